//--- source/uart_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module uart_fifo
    import uart_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       push_i,
    input  uart_byte_t data_i,
    input  logic       pop_i,
    output uart_byte_t data_o,
    output logic       full_o,
    output logic       empty_o
);

    localparam int               PTR_W      = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR   = PTR_W'(DEPTH - 1);
    localparam logic [PTR_W:0]   FULL_COUNT = (PTR_W + 1)'(DEPTH);

    uart_byte_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count_q == FULL_COUNT);
    assign empty_o = (count_q == '0);
    assign do_push = push_i & ~full_o; // dropped when full.
    assign do_pop  = pop_i & ~empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    assign data_o = mem[rd_ptr_q]; // head always visible.

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    a_count_bound: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        count_q <= FULL_COUNT
    );

endmodule

`default_nettype wire

//--- source/uart_pkg.sv
`default_nettype none

package uart_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [7:0]  uart_byte_t;
    typedef logic [15:0] clk_div_t;

    // register map.
    localparam apb_addr_t CLK_DIV_ADDR = 8'h00;
    localparam apb_addr_t CONTROL_ADDR = 8'h04;
    localparam apb_addr_t STATUS_ADDR  = 8'h08;
    localparam apb_addr_t TX_DATA_ADDR = 8'h0C;
    localparam apb_addr_t RX_DATA_ADDR = 8'h10;

    localparam int CTRL_BITS        = 4;
    localparam int CTRL_TX_RESET    = 0; // active high, holds the path in reset.
    localparam int CTRL_RX_RESET    = 1;
    localparam int CTRL_PARITY_EVEN = 2;
    localparam int CTRL_PARITY_ODD  = 3;

    localparam int STAT_RX_EMPTY   = 0;
    localparam int STAT_TX_FULL    = 1;
    localparam int STAT_PARITY_ERR = 2; // sticky.

    localparam clk_div_t MIN_CLK_DIV = 16'd4;

endpackage

`default_nettype wire

//--- source/uart_regs.sv
`timescale 1ns/10ps
`default_nettype none

module uart_regs
    import uart_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       psel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  apb_addr_t  paddr_i,
    input  apb_data_t  pwdata_i,
    input  logic       tx_full_i,
    input  logic       rx_empty_i,
    input  uart_byte_t rx_data_i,
    input  logic       parity_err_i,
    output apb_data_t  prdata_o,
    output logic       pready_o,
    output logic       tx_push_o,
    output uart_byte_t tx_data_o,
    output logic       rx_pop_o,
    output clk_div_t   clk_div_o,
    output logic       parity_even_o,
    output logic       parity_odd_o,
    output logic       tx_rst_n_o,
    output logic       rx_rst_n_o
);

    logic                 wr_access;
    logic                 rd_access;
    logic [CTRL_BITS-1:0] ctrl_q;
    clk_div_t             clk_div_q;
    logic                 parity_err_q;
    apb_data_t            status;

    // decode the access phase only.
    assign wr_access = psel_i & penable_i & pwrite_i;
    assign rd_access = psel_i & penable_i & ~pwrite_i;
    assign pready_o  = 1'b1;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ctrl_q    <= '0;
            clk_div_q <= '0; // engines idle until programmed.
        end else if (wr_access) begin
            if (paddr_i == CLK_DIV_ADDR) begin
                clk_div_q <= pwdata_i[15:0];
            end
            if (paddr_i == CONTROL_ADDR) begin
                ctrl_q <= pwdata_i[CTRL_BITS-1:0];
            end
        end
    end

    assign clk_div_o     = clk_div_q;
    assign parity_even_o = ctrl_q[CTRL_PARITY_EVEN];
    assign parity_odd_o  = ctrl_q[CTRL_PARITY_ODD];

    // path resets are held low while the control bit is set.
    assign tx_rst_n_o = rstn_i & ~ctrl_q[CTRL_TX_RESET];
    assign rx_rst_n_o = rstn_i & ~ctrl_q[CTRL_RX_RESET];

    // byte goes into the tx fifo on the edge ending the access.
    assign tx_push_o = wr_access & (paddr_i == TX_DATA_ADDR);
    assign tx_data_o = pwdata_i[7:0];

    assign rx_pop_o = rd_access & (paddr_i == RX_DATA_ADDR) & ~rx_empty_i;

    // only the rx path reset clears the flag.
    always_ff @(posedge clk_i) begin
        if (!rx_rst_n_o) begin
            parity_err_q <= 1'b0;
        end else if (parity_err_i) begin
            parity_err_q <= 1'b1;
        end
    end

    always_comb begin
        status                  = '0;
        status[STAT_RX_EMPTY]   = rx_empty_i;
        status[STAT_TX_FULL]    = tx_full_i;
        status[STAT_PARITY_ERR] = parity_err_q;
    end

    always_comb begin
        prdata_o = '0;
        if (rd_access) begin
            case (paddr_i)
                CLK_DIV_ADDR: prdata_o = apb_data_t'(clk_div_q);
                CONTROL_ADDR: prdata_o = apb_data_t'(ctrl_q);
                STATUS_ADDR:  prdata_o = status;
                RX_DATA_ADDR: begin
                    if (!rx_empty_i) begin
                        prdata_o = apb_data_t'(rx_data_i);
                    end
                end
                default:      prdata_o = '0;
            endcase
        end
    end

    // a pop only ends a read that was set up on RX_DATA.
    a_pop_after_setup: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        rx_pop_o |-> $past(psel_i && !penable_i && !pwrite_i && paddr_i == RX_DATA_ADDR)
    );

endmodule

`default_nettype wire

//--- source/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx
    import uart_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  clk_div_t   clk_div_i,
    input  logic       parity_even_i,
    input  logic       parity_odd_i,
    input  logic       uart_rx_i,
    output logic       push_o,
    output uart_byte_t data_o,
    output logic       parity_err_o
);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

    rx_state_t  state_q;
    clk_div_t   cnt_q;
    clk_div_t   half_div;
    logic [2:0] bit_idx_q;
    uart_byte_t shift_q;
    logic       par_q;
    logic       bad_q;
    logic       rx_meta_q;
    logic       rx_sync_q;
    logic       rx_prev_q;
    logic       enable;
    logic       bit_end;
    logic       odd_mode;
    logic       push_q;
    logic       err_q;

    assign enable   = (clk_div_i >= MIN_CLK_DIV);
    assign half_div = clk_div_i >> 1;
    assign bit_end  = (cnt_q == clk_div_i - 1'b1);
    assign odd_mode = ~parity_even_i & parity_odd_i;

    // two-flop synchronizer plus edge history.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
            rx_prev_q <= 1'b1;
        end else begin
            rx_meta_q <= uart_rx_i;
            rx_sync_q <= rx_meta_q;
            rx_prev_q <= rx_sync_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i || !enable) begin
            state_q <= RX_IDLE;
            cnt_q   <= '0;
            push_q  <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            push_q <= 1'b0;
            err_q  <= 1'b0;
            cnt_q  <= bit_end ? '0 : cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    if (rx_prev_q && !rx_sync_q) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    // mid start bit, later samples one period apart.
                    if (cnt_q == half_div - 1'b1) begin
                        cnt_q   <= '0;
                        state_q <= rx_sync_q ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end && bit_idx_q == 3'd7) begin
                        state_q <= (parity_even_i || parity_odd_i) ? RX_PARITY : RX_STOP;
                    end
                end
                RX_PARITY: if (bit_end) state_q <= RX_STOP;
                RX_STOP: begin
                    if (bit_end) begin
                        state_q <= RX_IDLE;
                        push_q  <= ~bad_q;
                        err_q   <= bad_q;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // payload assembly.
    always_ff @(posedge clk_i) begin
        if (state_q == RX_START) begin
            bit_idx_q <= '0;
            par_q     <= 1'b0;
            bad_q     <= 1'b0;
        end else if (bit_end && state_q == RX_DATA) begin
            shift_q   <= {rx_sync_q, shift_q[7:1]};
            par_q     <= par_q ^ rx_sync_q;
            bit_idx_q <= bit_idx_q + 1'b1;
        end else if (bit_end && state_q == RX_PARITY) begin
            bad_q <= rx_sync_q ^ par_q ^ odd_mode;
        end
    end

    assign push_o       = push_q;
    assign parity_err_o = err_q;
    assign data_o       = shift_q;

    a_push_xor_err: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !(push_o && parity_err_o)
    );

endmodule

`default_nettype wire

//--- source/uart_top.sv
`timescale 1ns/10ps
`default_nettype none

module uart_top
    import uart_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    input  logic      uart_rx_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      uart_tx_o
);

    logic       tx_push;
    uart_byte_t tx_data;
    logic       tx_full;
    logic       tx_empty;
    uart_byte_t tx_head;
    logic       tx_pop;
    logic       rx_push;
    uart_byte_t rx_byte;
    logic       rx_empty;
    uart_byte_t rx_head;
    logic       rx_pop;
    logic       parity_err;
    clk_div_t   clk_div;
    logic       parity_even;
    logic       parity_odd;
    logic       tx_rst_n;
    logic       rx_rst_n;

    uart_regs u_regs (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .tx_full_i    (tx_full),
        .rx_empty_i   (rx_empty),
        .rx_data_i    (rx_head),
        .parity_err_i (parity_err),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .tx_push_o    (tx_push),
        .tx_data_o    (tx_data),
        .rx_pop_o     (rx_pop),
        .clk_div_o    (clk_div),
        .parity_even_o(parity_even),
        .parity_odd_o (parity_odd),
        .tx_rst_n_o   (tx_rst_n),
        .rx_rst_n_o   (rx_rst_n)
    );

    uart_fifo #(.DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .clk_i  (clk_i),
        .rstn_i (tx_rst_n),
        .push_i (tx_push),
        .data_i (tx_data),
        .pop_i  (tx_pop),
        .data_o (tx_head),
        .full_o (tx_full),
        .empty_o(tx_empty)
    );

    uart_tx u_tx (
        .clk_i        (clk_i),
        .rstn_i       (tx_rst_n),
        .clk_div_i    (clk_div),
        .parity_even_i(parity_even),
        .parity_odd_i (parity_odd),
        .fifo_empty_i (tx_empty),
        .fifo_data_i  (tx_head),
        .fifo_pop_o   (tx_pop),
        .uart_tx_o    (uart_tx_o)
    );

    uart_rx u_rx (
        .clk_i        (clk_i),
        .rstn_i       (rx_rst_n),
        .clk_div_i    (clk_div),
        .parity_even_i(parity_even),
        .parity_odd_i (parity_odd),
        .uart_rx_i    (uart_rx_i),
        .push_o       (rx_push),
        .data_o       (rx_byte),
        .parity_err_o (parity_err)
    );

    // full rx fifo drops incoming bytes inside the fifo.
    uart_fifo #(.DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .clk_i  (clk_i),
        .rstn_i (rx_rst_n),
        .push_i (rx_push),
        .data_i (rx_byte),
        .pop_i  (rx_pop),
        .data_o (rx_head),
        .full_o (),
        .empty_o(rx_empty)
    );

endmodule

`default_nettype wire

//--- source/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx
    import uart_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  clk_div_t   clk_div_i,
    input  logic       parity_even_i,
    input  logic       parity_odd_i,
    input  logic       fifo_empty_i,
    input  uart_byte_t fifo_data_i,
    output logic       fifo_pop_o,
    output logic       uart_tx_o
);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_t;

    tx_state_t  state_q;
    clk_div_t   cnt_q;
    logic [2:0] bit_idx_q;
    uart_byte_t shift_q;
    logic       par_q;
    logic       tx_q;
    logic       enable;
    logic       bit_end;
    logic       next_data;

    assign enable    = (clk_div_i >= MIN_CLK_DIV);
    assign bit_end   = (cnt_q == clk_div_i - 1'b1);
    assign next_data = bit_end & ((state_q == TX_START) |
                                  ((state_q == TX_DATA) & (bit_idx_q != 3'd7)));

    assign fifo_pop_o = (state_q == TX_IDLE) & enable & ~fifo_empty_i;
    assign uart_tx_o  = tx_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i || !enable) begin
            state_q <= TX_IDLE;
            cnt_q   <= '0;
            tx_q    <= 1'b1; // line idles high.
        end else begin
            cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
            case (state_q)
                TX_IDLE: begin
                    cnt_q <= '0;
                    if (fifo_pop_o) begin
                        state_q <= TX_START;
                        tx_q    <= 1'b0;
                    end
                end
                TX_START: if (bit_end) state_q <= TX_DATA;
                TX_DATA: begin
                    if (bit_end && bit_idx_q == 3'd7) begin
                        if (parity_even_i || parity_odd_i) begin
                            state_q <= TX_PARITY;
                            tx_q    <= par_q ^ (~parity_even_i & parity_odd_i);
                        end else begin
                            state_q <= TX_STOP;
                            tx_q    <= 1'b1;
                        end
                    end
                end
                TX_PARITY: begin
                    if (bit_end) begin
                        state_q <= TX_STOP;
                        tx_q    <= 1'b1;
                    end
                end
                TX_STOP:  if (bit_end) state_q <= TX_IDLE;
                default:  state_q <= TX_IDLE;
            endcase
            if (next_data) begin
                tx_q <= shift_q[0]; // lsb first.
            end
        end
    end

    // shifter and running parity.
    always_ff @(posedge clk_i) begin
        if (fifo_pop_o) begin
            shift_q   <= fifo_data_i;
            par_q     <= 1'b0;
            bit_idx_q <= '0;
        end else if (next_data) begin
            shift_q <= shift_q >> 1;
            par_q   <= par_q ^ shift_q[0];
            if (state_q == TX_DATA) begin
                bit_idx_q <= bit_idx_q + 1'b1;
            end
        end
    end

    a_idle_high: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (state_q == TX_IDLE) |-> uart_tx_o
    );

endmodule

`default_nettype wire

//--- tb/tb_checker.sv
`timescale 1ns/10ps
`default_nettype none

module tb_checker
    import uart_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       psel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  apb_addr_t  paddr_i,
    input  apb_data_t  pwdata_i,
    input  apb_data_t  prdata_i,
    input  logic       pready_i,
    input  logic       uart_tx_i,
    input  logic       compare_i,
    input  apb_data_t  expected_i,
    input  logic [7:0] test_num_i,
    input  logic       end_i,
    output int         fail_count_o,
    output logic       done_o
);

    uart_byte_t           tx_queue[$]; // bytes written but not yet seen on the line.
    clk_div_t             div_q;
    logic [CTRL_BITS-1:0] ctrl_q;
    logic                 line_checked;
    logic                 prev_line;
    logic                 frame_busy;
    int                   cur_test;
    int                   test_checks;
    int                   test_errors;
    int                   tests_passed;
    int                   tests_failed;
    int                   total_errors;

    initial begin
        div_q        = '0;
        ctrl_q       = '0;
        line_checked = 1'b0;
        prev_line    = 1'b1;
        frame_busy   = 1'b0;
        cur_test     = 0;
        test_checks  = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        total_errors = 0;
        fail_count_o = 0;
        done_o       = 1'b0;
    end

    task record_check(input logic ok);
        test_checks++;
        if (!ok) begin
            test_errors++;
            total_errors++;
        end
    endtask

    task finish_test;
        if (test_errors == 0) tests_passed++;
        else tests_failed++;
        $display("test %0d done: %0d checks, %0d errors", cur_test, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    always @(posedge clk_i) begin
        if (test_num_i != cur_test) begin
            if (cur_test != 0) finish_test();
            cur_test = test_num_i;
        end
        if (!rstn_i) begin
            div_q  = '0;
            ctrl_q = '0;
        end else begin
            if (!line_checked) begin
                line_checked = 1'b1;
                if (uart_tx_i !== 1'b1) begin
                    $display("CHECK FAILED uart_tx_o after reset: expected 1, actual %h",
                             uart_tx_i);
                end
                record_check(uart_tx_i === 1'b1);
            end
            if (psel_i && penable_i) begin
                // no wait states, every access completes at once.
                if (pready_i !== 1'b1) begin
                    $display("CHECK FAILED pready_o: expected 1, actual %h", pready_i);
                end
                record_check(pready_i === 1'b1);
            end
            if (psel_i && penable_i && pwrite_i) begin
                case (paddr_i)
                    CLK_DIV_ADDR: div_q = pwdata_i[15:0];
                    CONTROL_ADDR: begin
                        ctrl_q = pwdata_i[CTRL_BITS-1:0];
                        if (pwdata_i[CTRL_TX_RESET]) tx_queue.delete(); // fifo emptied.
                    end
                    TX_DATA_ADDR: tx_queue.push_back(pwdata_i[7:0]);
                    default: ;
                endcase
            end
            if (compare_i && psel_i && penable_i && !pwrite_i) begin
                if (prdata_i !== expected_i) begin
                    $display("CHECK FAILED prdata_o at %h: expected %h, actual %h",
                             paddr_i, expected_i, prdata_i);
                end
                record_check(prdata_i === expected_i);
            end
            if (end_i && !done_o) begin
                if (frame_busy) begin
                    $display("run ended while a frame was still on uart_tx_o");
                    record_check(1'b0);
                end
                if (tx_queue.size() != 0) begin
                    $display("%0d bytes written to TX_DATA never appeared on uart_tx_o",
                             tx_queue.size());
                    record_check(1'b0);
                end
                finish_test();
                $display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
                         tests_passed, tests_failed, total_errors);
                fail_count_o = total_errors;
                done_o       = 1'b1;
            end
        end
    end

    // samples each bit in its middle, counted from the start edge.
    task decode_frame;
        uart_byte_t got;
        uart_byte_t exp;
        logic       par_en;
        logic       par_bit;
        logic       par_exp;
        logic       stop_bit;
        int         div;
        int         i;
        frame_busy = 1'b1;
        div        = div_q;
        par_en     = ctrl_q[CTRL_PARITY_EVEN] | ctrl_q[CTRL_PARITY_ODD];
        par_bit    = 1'b0;
        repeat (div / 2 - 1) @(posedge clk_i);
        for (i = 0; i < 8; i++) begin
            repeat (div) @(posedge clk_i);
            got[i] = uart_tx_i;
        end
        if (par_en) begin
            repeat (div) @(posedge clk_i);
            par_bit = uart_tx_i;
        end
        repeat (div) @(posedge clk_i);
        stop_bit   = uart_tx_i;
        prev_line  = stop_bit;
        frame_busy = 1'b0;
        if (tx_queue.size() == 0) begin
            $display("frame with data %h on uart_tx_o but no byte was written to TX_DATA", got);
            record_check(1'b0);
        end else begin
            exp = tx_queue.pop_front();
            if (got !== exp) begin
                $display("CHECK FAILED uart_tx_o data: expected %h, actual %h", exp, got);
            end
            record_check(got === exp);
            if (par_en) begin
                // even when the even bit is set, odd only with the odd bit alone.
                par_exp = (^exp) ^ (~ctrl_q[CTRL_PARITY_EVEN] & ctrl_q[CTRL_PARITY_ODD]);
                if (par_bit !== par_exp) begin
                    $display("CHECK FAILED uart_tx_o parity: expected %h, actual %h",
                             par_exp, par_bit);
                end
                record_check(par_bit === par_exp);
            end
        end
        if (stop_bit !== 1'b1) begin
            $display("CHECK FAILED uart_tx_o stop bit: expected 1, actual %h", stop_bit);
        end
        record_check(stop_bit === 1'b1);
    endtask

    initial begin
        forever begin
            @(posedge clk_i);
            if (rstn_i && prev_line === 1'b1 && uart_tx_i === 1'b0) begin
                decode_frame();
            end else begin
                prev_line = uart_tx_i;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_top
    import uart_pkg::*;
();

    localparam int FIFO_DEPTH = 4;
    localparam int HALF_PERIOD = 20;

    logic       clk;
    logic       rstn;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    apb_data_t  pwdata;
    apb_data_t  prdata;
    logic       pready;
    logic       uart_tx;
    logic       uart_rx;
    logic       rx_force;
    logic       rx_bit;
    logic       compare;
    apb_data_t  expected;
    logic [7:0] test_num;
    logic       run_end;
    logic       report_done;
    int         fail_count;

    logic [7:0]  test_q[$];
    logic [15:0] op_q[$];
    apb_addr_t   addr_q[$];
    apb_data_t   data_q[$];
    apb_data_t   exp_q[$];

    clk_div_t             cur_div;
    logic [CTRL_BITS-1:0] cur_ctrl;
    int                   max_div;
    int                   file_errors;
    int                   cycle_limit;
    int                   cycle_count;

    // loopback unless a raw frame is being injected.
    assign uart_rx = rx_force ? rx_bit : uart_tx;

    uart_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut0 (
        .clk_i    (clk),
        .rstn_i   (rstn),
        .psel_i   (psel),
        .penable_i(penable),
        .pwrite_i (pwrite),
        .paddr_i  (paddr),
        .pwdata_i (pwdata),
        .uart_rx_i(uart_rx),
        .prdata_o (prdata),
        .pready_o (pready),
        .uart_tx_o(uart_tx)
    );

    tb_checker checker0 (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .psel_i      (psel),
        .penable_i   (penable),
        .pwrite_i    (pwrite),
        .paddr_i     (paddr),
        .pwdata_i    (pwdata),
        .prdata_i    (prdata),
        .pready_i    (pready),
        .uart_tx_i   (uart_tx),
        .compare_i   (compare),
        .expected_i  (expected),
        .test_num_i  (test_num),
        .end_i       (run_end),
        .fail_count_o(fail_count),
        .done_o      (report_done)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    task load_ops;
        int          fd;
        int          n;
        int          tn;
        string       line;
        logic [15:0] op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("tb/uart_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/uart_input.txt");
            file_errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                // comment and blank lines do not scan as five fields.
                if (n > 0 && $sscanf(line, "%d %s %h %h %h", tn, op, a, d, e) == 5) begin
                    test_q.push_back(tn[7:0]);
                    op_q.push_back(op);
                    addr_q.push_back(a[7:0]);
                    data_q.push_back(d);
                    exp_q.push_back(e);
                    if (op == "W" && a[7:0] == CLK_DIV_ADDR && int'(d) > max_div) begin
                        max_div = int'(d);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // setup phase, access phase, then back to idle.
    task apb_access(input logic wr, input apb_addr_t a, input apb_data_t d,
                    input logic cmp, input apb_data_t exp, output apb_data_t rdata);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= a;
        pwdata  <= wr ? d : '0;
        @(posedge clk);
        penable  <= 1'b1;
        compare  <= cmp;
        expected <= exp;
        @(posedge clk);
        rdata = prdata; // access phase still on the bus here.
        psel    <= 1'b0;
        penable <= 1'b0;
        compare <= 1'b0;
    endtask

    task inject_frame(input uart_byte_t b);
        logic [10:0] bits;
        logic        good_par;
        int          i;
        good_par = (^b) ^ (~cur_ctrl[CTRL_PARITY_EVEN] & cur_ctrl[CTRL_PARITY_ODD]);
        bits = {1'b1, ~good_par, b, 1'b0}; // stop, wrong parity, data, start.
        @(posedge clk);
        rx_force <= 1'b1;
        for (i = 0; i < 11; i++) begin
            rx_bit <= bits[i];
            repeat (cur_div) @(posedge clk);
        end
        repeat (cur_div) @(posedge clk); // idle tail covers the stop sample.
        rx_force <= 1'b0;
    endtask

    task run_op(input int idx);
        apb_data_t rdata;
        int        gap;
        gap = $urandom % 3;
        repeat (gap) @(posedge clk);
        test_num <= test_q[idx];
        case (op_q[idx])
            "W": begin
                apb_access(1'b1, addr_q[idx], data_q[idx], 1'b0, '0, rdata);
                if (addr_q[idx] == CLK_DIV_ADDR) cur_div = data_q[idx][15:0];
                if (addr_q[idx] == CONTROL_ADDR) cur_ctrl = data_q[idx][CTRL_BITS-1:0];
            end
            "R": apb_access(1'b0, addr_q[idx], '0, 1'b1, exp_q[idx], rdata);
            "I": inject_frame(data_q[idx][7:0]);
            "Wt": begin
                rdata = '1;
                while (rdata[STAT_RX_EMPTY]) begin
                    apb_access(1'b0, STATUS_ADDR, '0, 1'b0, '0, rdata);
                end
            end
            default: begin
                $display("operation %0d has an unknown opcode", idx + 1);
                file_errors++;
            end
        endcase
    endtask

    initial begin
        void'($urandom(12191));
        rstn        = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        rx_force    = 1'b0;
        rx_bit      = 1'b1;
        compare     = 1'b0;
        expected    = '0;
        run_end     = 1'b0;
        test_num    = '0;
        cur_div     = '0;
        cur_ctrl    = '0;
        max_div     = 0;
        file_errors = 0;
        load_ops();
        cycle_limit = (op_q.size() + 1) * (12 * max_div + 20);
        if (test_q.size() > 0) test_num = test_q[0];
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        foreach (op_q[i]) begin
            run_op(i);
        end
        @(posedge clk);
        run_end <= 1'b1;
        wait (report_done);
        if (fail_count == 0 && file_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // limit follows from the number of operations and the slowest divider.
    initial begin
        cycle_count = 0;
        while (cycle_limit == 0 || cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run timed out after %0d cycles without finishing", cycle_count);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/uart_input.txt
# columns: test opcode address(hex) data(hex) expected(hex)
# opcodes: W write, R read and compare, I inject bad parity frame, Wt wait for rx data
1 R  08 00000000 00000001
2 W  00 00000008 00000000
2 W  0C 00000055 00000000
2 W  0C 000000A3 00000000
2 W  0C 0000000F 00000000
2 Wt 08 00000000 00000000
2 R  10 00000000 00000055
2 Wt 08 00000000 00000000
2 R  10 00000000 000000A3
2 Wt 08 00000000 00000000
2 R  10 00000000 0000000F
2 R  08 00000000 00000001
3 W  04 00000004 00000000
3 W  0C 00000096 00000000
3 W  0C 00000001 00000000
3 W  0C 000000E7 00000000
3 Wt 08 00000000 00000000
3 R  10 00000000 00000096
3 Wt 08 00000000 00000000
3 R  10 00000000 00000001
3 Wt 08 00000000 00000000
3 R  10 00000000 000000E7
3 W  04 00000008 00000000
3 W  0C 0000003C 00000000
3 W  0C 00000080 00000000
3 W  0C 00000007 00000000
3 Wt 08 00000000 00000000
3 R  10 00000000 0000003C
3 Wt 08 00000000 00000000
3 R  10 00000000 00000080
3 Wt 08 00000000 00000000
3 R  10 00000000 00000007
3 R  08 00000000 00000001
4 W  04 00000004 00000000
4 I  00 0000005A 00000000
4 R  08 00000000 00000005
4 R  10 00000000 00000000
4 W  04 00000006 00000000
4 W  04 00000004 00000000
4 R  08 00000000 00000001
5 W  00 00000002 00000000
5 W  04 00000000 00000000
5 W  0C 00000011 00000000
5 W  0C 00000022 00000000
5 W  0C 00000033 00000000
5 W  0C 00000044 00000000
5 R  08 00000000 00000003
5 W  04 00000001 00000000
5 W  04 00000000 00000000
5 R  08 00000000 00000001

//--- vlog.f
source/uart_pkg.sv
source/uart_regs.sv
source/uart_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_top.sv
tb/tb_checker.sv
tb/tb_top.sv
